// File: testbench/lite_mem_vectors.txt
// Per port: op(0 idle,1 read,2 write,3 race read) addr wdata strb exp_rdata exp_resp
// Port 0 columns first, then port 1; resp 0 is OKAY, 2 is SLVERR
2 00000000 DEADBEEF F 00000000 0   0 00000000 00000000 0 00000000 0
1 00000000 00000000 0 DEADBEEF 0   0 00000000 00000000 0 00000000 0
0 00000000 00000000 0 00000000 0   2 00000010 11223344 5 00000000 0
1 00000014 00000000 0 00000000 0   1 00000010 00000000 0 00220044 0
0 00000000 00000000 0 00000000 0   2 00000010 AABBCCDD 2 00000000 0
1 00000010 00000000 0 0022CC44 0   1 00000000 00000000 0 DEADBEEF 0
2 00000020 CAFEF00D F 00000000 0   2 00000024 12345678 F 00000000 0
1 00000024 00000000 0 12345678 0   1 00000020 00000000 0 CAFEF00D 0
2 00000030 A5A5A5A5 F 00000000 0   2 00000030 5A5A5A5A F 00000000 0
3 00000030 5A5A5A5A 0 A5A5A5A5 0   3 00000030 5A5A5A5A 0 A5A5A5A5 0
2 00000400 FFFFFFFF F 00000000 2   1 000003FC 00000000 0 00000000 0
1 00000000 00000000 0 DEADBEEF 0   1 00000800 00000000 0 00000000 2
1 00000400 00000000 0 00000000 2   2 FFFFFFFC 0BADF00D F 00000000 2
1 00000000 00000000 0 DEADBEEF 0   1 00000000 00000000 0 DEADBEEF 0
2 000003FC 01020304 F 00000000 0   2 00000100 FFFF0000 C 00000000 0
1 00000100 00000000 0 FFFF0000 0   1 000003FC 00000000 0 01020304 0
2 00000100 000000EE 1 00000000 0   1 00000024 00000000 0 12345678 0
1 00000020 00000000 0 CAFEF00D 0   1 00000100 00000000 0 FFFF00EE 0

// File: flist.f
+incdir+source
source/lite_mem_pkg.sv
source/axi_lite_to_mem.sv
source/mem_req_arbiter.sv
source/tcdm_bank.sv
source/lite_mem_top.sv
testbench/lite_mem_assertions.sv
testbench/tb_lite_mem.sv

// File: Bender.yml
package:
  name: lite_mem

sources:
  - include_dirs:
      - source
    files:
      - source/lite_mem_pkg.sv
      - source/axi_lite_to_mem.sv
      - source/mem_req_arbiter.sv
      - source/tcdm_bank.sv
      - source/lite_mem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/lite_mem_assertions.sv
      - testbench/tb_lite_mem.sv

// File: testbench/tb_lite_mem.sv
`timescale 1ns/100ps

module tb_lite_mem import lite_mem_pkg::*; ();

  // Six hex columns per port, two ports per line
  localparam int port_cols = 6;
  localparam int line_cols = 2 * port_cols;
  localparam int max_lines = 64;

  logic clk;
  logic reset;
  int   seed = 34461;
  int   num_lines = 0;

  logic [31:0] vec_mem [line_cols*max_lines];
  lm_data_t    read_result [2];

  // AXI4-Lite signals, index is the port number
  lm_addr_t awaddr [2];
  logic     awvalid [2];
  logic     awready [2];
  lm_data_t wdata [2];
  lm_strb_t wstrb [2];
  logic     wvalid [2];
  logic     wready [2];
  lm_resp_t bresp [2];
  logic     bvalid [2];
  logic     bready [2];
  lm_addr_t araddr [2];
  logic     arvalid [2];
  logic     arready [2];
  lm_data_t rdata [2];
  lm_resp_t rresp [2];
  logic     rvalid [2];
  logic     rready [2];

  lite_mem_top u_lite_mem_top (
    .clk_i(clk), .reset_i(reset),
    .p0_awaddr_i(awaddr[0]), .p0_awvalid_i(awvalid[0]), .p0_awready_o(awready[0]),
    .p0_wdata_i(wdata[0]), .p0_wstrb_i(wstrb[0]),
    .p0_wvalid_i(wvalid[0]), .p0_wready_o(wready[0]),
    .p0_bresp_o(bresp[0]), .p0_bvalid_o(bvalid[0]), .p0_bready_i(bready[0]),
    .p0_araddr_i(araddr[0]), .p0_arvalid_i(arvalid[0]), .p0_arready_o(arready[0]),
    .p0_rdata_o(rdata[0]), .p0_rresp_o(rresp[0]),
    .p0_rvalid_o(rvalid[0]), .p0_rready_i(rready[0]),
    .p1_awaddr_i(awaddr[1]), .p1_awvalid_i(awvalid[1]), .p1_awready_o(awready[1]),
    .p1_wdata_i(wdata[1]), .p1_wstrb_i(wstrb[1]),
    .p1_wvalid_i(wvalid[1]), .p1_wready_o(wready[1]),
    .p1_bresp_o(bresp[1]), .p1_bvalid_o(bvalid[1]), .p1_bready_i(bready[1]),
    .p1_araddr_i(araddr[1]), .p1_arvalid_i(arvalid[1]), .p1_arready_o(arready[1]),
    .p1_rdata_o(rdata[1]), .p1_rresp_o(rresp[1]),
    .p1_rvalid_o(rvalid[1]), .p1_rready_i(rready[1])
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic end_in_failure();
    $display("sim failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_data(input string name, input lm_data_t got, input lm_data_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_resp(input string name, input lm_resp_t got, input lm_resp_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end_in_failure();
    end
  endtask

  // Sum over the arbiter and both bridge assertion instances
  function automatic int assertion_failures();
    assertion_failures = u_lite_mem_top.u_arbiter.u_arb_assertions.fail_count
                       + u_lite_mem_top.u_bridge_p0.u_bridge_assertions.fail_count
                       + u_lite_mem_top.u_bridge_p1.u_bridge_assertions.fail_count;
  endfunction

  // Ready is high about three cycles in four
  function automatic logic ready_draw();
    ready_draw = ($random(seed) % 4) != 0;
  endfunction

  task automatic write_op(input int p, input lm_addr_t addr, input lm_data_t data,
                          input lm_strb_t strb, output lm_resp_t resp);
    awaddr[p]  = addr;
    wdata[p]   = data;
    wstrb[p]   = strb;
    awvalid[p] = 1'b1;
    wvalid[p]  = 1'b1;
    bready[p]  = ready_draw();
    // AW and W are accepted in the same cycle
    do @(negedge clk); while (!(awready[p] && wready[p]));
    @(posedge clk);
    #2;
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
    while (1) begin
      @(negedge clk);
      if (bvalid[p] && bready[p]) break;
      @(posedge clk);
      #2;
      bready[p] = ready_draw();
    end
    resp = bresp[p];
    @(posedge clk);
    #2;
    bready[p] = 1'b0;
    @(negedge clk);
    if (bvalid[p]) begin
      $display("Port %0d kept bvalid high after its write response was taken", p);
      end_in_failure();
    end
  endtask

  task automatic read_op(input int p, input lm_addr_t addr,
                         output lm_data_t data, output lm_resp_t resp);
    araddr[p]  = addr;
    arvalid[p] = 1'b1;
    rready[p]  = ready_draw();
    do @(negedge clk); while (!arready[p]);
    @(posedge clk);
    #2;
    arvalid[p] = 1'b0;
    while (1) begin
      @(negedge clk);
      if (rvalid[p] && rready[p]) break;
      @(posedge clk);
      #2;
      rready[p] = ready_draw();
    end
    data = rdata[p];
    resp = rresp[p];
    @(posedge clk);
    #2;
    rready[p] = 1'b0;
    @(negedge clk);
    if (rvalid[p]) begin
      $display("Port %0d kept rvalid high after its read response was taken", p);
      end_in_failure();
    end
  endtask

  // Op codes: 0 idle, 1 read, 2 write, 3 read that may match either race word
  task automatic run_port(input int p, input int line);
    int       base;
    int       op;
    lm_addr_t addr;
    lm_data_t wd;
    lm_strb_t st;
    lm_data_t exp_d;
    lm_resp_t exp_r;
    lm_data_t got_d;
    lm_resp_t got_r;
    base  = line * line_cols + p * port_cols;
    op    = vec_mem[base];
    addr  = vec_mem[base+1];
    wd    = vec_mem[base+2];
    st    = lm_strb_t'(vec_mem[base+3]);
    exp_d = vec_mem[base+4];
    exp_r = lm_resp_t'(vec_mem[base+5][1:0]);
    case (op)
      0: begin
      end
      2: begin
        write_op(p, addr, wd, st, got_r);
        check_resp($sformatf("p%0d_bresp", p), got_r, exp_r);
      end
      1, 3: begin
        read_op(p, addr, got_d, got_r);
        check_resp($sformatf("p%0d_rresp", p), got_r, exp_r);
        // Race reads accept the second written word from the wdata column
        if (!(op == 3 && got_d === wd)) begin
          check_data($sformatf("p%0d_rdata", p), got_d, exp_d);
        end
        read_result[p] = got_d;
      end
      default: begin
        $display("Unknown operation code %0d for port %0d in vector line %0d", op, p, line);
        end_in_failure();
      end
    endcase
  endtask

  // Limit scales with the number of vector lines
  initial begin
    wait (num_lines > 0);
    #((num_lines * 40 + 5) * 20);
    $display("Timeout: vectors did not finish within %0d cycles", num_lines * 40 + 5);
    end_in_failure();
  end

  // Stop at the first protocol assertion that fires
  initial begin
    do @(negedge clk); while (assertion_failures() == 0);
    $display("A protocol assertion on the arbiter or a bridge failed");
    end_in_failure();
  end

  initial begin
    int n;
    reset = 1'b1;
    for (int p = 0; p < 2; p++) begin
      awaddr[p]  = '0;
      awvalid[p] = 1'b0;
      wdata[p]   = '0;
      wstrb[p]   = '0;
      wvalid[p]  = 1'b0;
      bready[p]  = 1'b0;
      araddr[p]  = '0;
      arvalid[p] = 1'b0;
      rready[p]  = 1'b0;
    end
    $readmemh("testbench/lite_mem_vectors.txt", vec_mem);
    // Lines never filled keep an unknown op code
    n = 0;
    while (n < max_lines && vec_mem[n*line_cols] !== 'x) n++;
    if (n == 0) begin
      $display("No vector lines could be read from the vectors file");
      end_in_failure();
    end
    num_lines = n;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int line = 0; line < num_lines; line++) begin
      fork
        run_port(0, line);
        run_port(1, line);
      join
      // Same-address race must leave one agreed value
      if (vec_mem[line*line_cols] == 3 && vec_mem[line*line_cols+port_cols] == 3) begin
        check_data("p1_rdata vs p0_rdata", read_result[1], read_result[0]);
      end
      @(posedge clk);
      #2;
    end
    if (assertion_failures() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("A protocol assertion failed in the last cycle of the run");
      end_in_failure();
    end
  end

endmodule

// File: testbench/lite_mem_assertions.sv
`timescale 1ns/100ps

`include "lite_mem_cfg.svh"

module lite_mem_assertions (
  input logic                     clk_i,
  input logic                     reset_i,
  // Arbiter side, tied low in the bridge binding
  input logic [`LM_NUM_PORTS-1:0] req_i,
  input logic [`LM_NUM_PORTS-1:0] gnt_i,
  input logic [`LM_NUM_PORTS-1:0] rsp_i,
  // Bridge side, tied low in the arbiter binding
  input logic                     bvalid_i,
  input logic                     bready_i,
  input logic                     rvalid_i,
  input logic                     rready_i
);

  // Failed assertions of this instance
  int unsigned fail_count = 0;

  for (genvar k = 0; k < `LM_NUM_PORTS; k++) begin : g_rsp
    // Port that loses arbitration wins the next cycle
    a_no_starve: assert property (@(posedge clk_i) disable iff (reset_i)
      req_i[k] && !gnt_i[k] |=> gnt_i[k])
      else begin
        $error("Request on port %0d waited more than one cycle", k);
        fail_count++;
      end

    // Bank answers the granted port next cycle
    a_gnt_rsp: assert property (@(posedge clk_i) disable iff (reset_i) gnt_i[k] |=> rsp_i[k])
      else begin
        $error("Grant on port %0d without rvalid one cycle later", k);
        fail_count++;
      end
  end

  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  // First cycle out of reset has no response valid or grant
  a_reset_quiet: assert property (@(posedge clk_i) $past(reset_i) && !reset_i |->
    !(bvalid_i || rvalid_i || (|gnt_i) || (|rsp_i)))
    else begin
      $error("Valid or grant high in the cycle after reset");
      fail_count++;
    end

endmodule

bind mem_req_arbiter lite_mem_assertions u_arb_assertions (
  .clk_i(clk_i), .reset_i(reset_i),
  .req_i({req_i[1], req_i[0]}),
  .gnt_i({gnt_o[1], gnt_o[0]}), .rsp_i({rvalid_o[1], rvalid_o[0]}),
  .bvalid_i(1'b0), .bready_i(1'b0), .rvalid_i(1'b0), .rready_i(1'b0)
);

bind axi_lite_to_mem lite_mem_assertions u_bridge_assertions (
  .clk_i(clk_i), .reset_i(reset_i),
  .req_i(2'b00), .gnt_i(2'b00), .rsp_i(2'b00),
  .bvalid_i(bvalid_o), .bready_i(bready_i), .rvalid_i(rvalid_o), .rready_i(rready_i)
);

// File: source/lite_mem_top.sv
`timescale 1ns/100ps

`include "lite_mem_cfg.svh"

module lite_mem_top import lite_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // Port 0
  input  lm_addr_t p0_awaddr_i,
  input  logic     p0_awvalid_i,
  output logic     p0_awready_o,
  input  lm_data_t p0_wdata_i,
  input  lm_strb_t p0_wstrb_i,
  input  logic     p0_wvalid_i,
  output logic     p0_wready_o,
  output lm_resp_t p0_bresp_o,
  output logic     p0_bvalid_o,
  input  logic     p0_bready_i,
  input  lm_addr_t p0_araddr_i,
  input  logic     p0_arvalid_i,
  output logic     p0_arready_o,
  output lm_data_t p0_rdata_o,
  output lm_resp_t p0_rresp_o,
  output logic     p0_rvalid_o,
  input  logic     p0_rready_i,
  // Port 1
  input  lm_addr_t p1_awaddr_i,
  input  logic     p1_awvalid_i,
  output logic     p1_awready_o,
  input  lm_data_t p1_wdata_i,
  input  lm_strb_t p1_wstrb_i,
  input  logic     p1_wvalid_i,
  output logic     p1_wready_o,
  output lm_resp_t p1_bresp_o,
  output logic     p1_bvalid_o,
  input  logic     p1_bready_i,
  input  lm_addr_t p1_araddr_i,
  input  logic     p1_arvalid_i,
  output logic     p1_arready_o,
  output lm_data_t p1_rdata_o,
  output lm_resp_t p1_rresp_o,
  output logic     p1_rvalid_o,
  input  logic     p1_rready_i
);

  // Bridge to arbiter, one entry per port
  logic        mem_req     [`LM_NUM_PORTS];
  lm_mem_req_t mem_payload [`LM_NUM_PORTS];
  logic        mem_gnt     [`LM_NUM_PORTS];
  logic        mem_rvalid  [`LM_NUM_PORTS];
  lm_data_t    mem_rdata   [`LM_NUM_PORTS];

  // Arbiter to bank
  logic        bank_req;
  lm_mem_req_t bank_payload;
  logic        bank_gnt;
  logic        bank_rvalid;
  lm_data_t    bank_rdata;

  // Port 0 bridge
  axi_lite_to_mem u_bridge_p0 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .awaddr_i  (p0_awaddr_i), .awvalid_i(p0_awvalid_i), .awready_o(p0_awready_o),
    .wdata_i   (p0_wdata_i),  .wstrb_i  (p0_wstrb_i),
    .wvalid_i  (p0_wvalid_i), .wready_o (p0_wready_o),
    .bresp_o   (p0_bresp_o),  .bvalid_o (p0_bvalid_o),  .bready_i (p0_bready_i),
    .araddr_i  (p0_araddr_i), .arvalid_i(p0_arvalid_i), .arready_o(p0_arready_o),
    .rdata_o   (p0_rdata_o),  .rresp_o  (p0_rresp_o),
    .rvalid_o  (p0_rvalid_o), .rready_i (p0_rready_i),
    .mem_req_o    (mem_req[0]),
    .mem_payload_o(mem_payload[0]),
    .mem_gnt_i    (mem_gnt[0]),
    .mem_rvalid_i (mem_rvalid[0]),
    .mem_rdata_i  (mem_rdata[0])
  );

  // Port 1 bridge
  axi_lite_to_mem u_bridge_p1 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .awaddr_i  (p1_awaddr_i), .awvalid_i(p1_awvalid_i), .awready_o(p1_awready_o),
    .wdata_i   (p1_wdata_i),  .wstrb_i  (p1_wstrb_i),
    .wvalid_i  (p1_wvalid_i), .wready_o (p1_wready_o),
    .bresp_o   (p1_bresp_o),  .bvalid_o (p1_bvalid_o),  .bready_i (p1_bready_i),
    .araddr_i  (p1_araddr_i), .arvalid_i(p1_arvalid_i), .arready_o(p1_arready_o),
    .rdata_o   (p1_rdata_o),  .rresp_o  (p1_rresp_o),
    .rvalid_o  (p1_rvalid_o), .rready_i (p1_rready_i),
    .mem_req_o    (mem_req[1]),
    .mem_payload_o(mem_payload[1]),
    .mem_gnt_i    (mem_gnt[1]),
    .mem_rvalid_i (mem_rvalid[1]),
    .mem_rdata_i  (mem_rdata[1])
  );

  // Round-robin share of the single bank
  mem_req_arbiter #(
    .payload_t(lm_mem_req_t),
    .N_PORTS  (`LM_NUM_PORTS)
  ) u_arbiter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (mem_req),
    .payload_i     (mem_payload),
    .gnt_o         (mem_gnt),
    .rvalid_o      (mem_rvalid),
    .rdata_o       (mem_rdata),
    .bank_req_o    (bank_req),
    .bank_payload_o(bank_payload),
    .bank_gnt_i    (bank_gnt),
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata)
  );

  // Shared scratch memory
  tcdm_bank u_bank (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (bank_req),
    .payload_i(bank_payload),
    .gnt_o    (bank_gnt),
    .rvalid_o (bank_rvalid),
    .rdata_o  (bank_rdata)
  );

endmodule

// File: source/tcdm_bank.sv
`timescale 1ns/100ps

`include "lite_mem_cfg.svh"

module tcdm_bank import lite_mem_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        req_i,
  input  lm_mem_req_t payload_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output lm_data_t    rdata_o
);

  // Word storage
  lm_data_t mem_q [`LM_MEM_WORDS];

  logic     rvalid_q;
  lm_data_t rdata_q;

  // Bank never stalls
  assign gnt_o = req_i;

  // Storage, cleared on reset so reads are known
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int unsigned w = 0; w < `LM_MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (req_i && payload_i.we) begin
      // Only strobed lanes change
      for (int unsigned b = 0; b < `LM_STRB_W; b++) begin
        if (payload_i.strb[b]) begin
          mem_q[payload_i.index][8*b +: 8] <= payload_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read word registered at the grant
  always_ff @(posedge clk_i) begin
    if (req_i && !payload_i.we) begin
      rdata_q <= mem_q[payload_i.index];
    end
  end

  // Acknowledge one cycle after every grant, write or read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// File: source/mem_req_arbiter.sv
`timescale 1ns/100ps

module mem_req_arbiter import lite_mem_pkg::*; #(
  parameter type         payload_t = lm_mem_req_t,
  parameter int unsigned N_PORTS   = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  // Requester side
  input  logic     req_i      [N_PORTS],
  input  payload_t payload_i  [N_PORTS],
  output logic     gnt_o      [N_PORTS],
  output logic     rvalid_o   [N_PORTS],
  output lm_data_t rdata_o    [N_PORTS],
  // Bank side
  output logic     bank_req_o,
  output payload_t bank_payload_o,
  input  logic     bank_gnt_i,
  input  logic     bank_rvalid_i,
  input  lm_data_t bank_rdata_i
);

  localparam int unsigned idx_w = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

  // Port with the highest priority this cycle
  logic [idx_w-1:0] prio_q;
  // Winner of the current cycle
  logic [idx_w-1:0] win;
  logic             found;
  // Port whose grant was given last cycle
  logic [idx_w-1:0] rsp_win_q;
  logic             granted;

  // Scan from the priority pointer, first request wins
  always_comb begin : pick
    int unsigned idx;
    found = 1'b0;
    win   = '0;
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      idx = (prio_q + i) % N_PORTS;
      if (!found && req_i[idx]) begin
        found = 1'b1;
        win   = idx_w'(idx);
      end
    end
  end

  assign bank_req_o     = found;
  assign bank_payload_o = payload_i[win];
  assign granted        = found && bank_gnt_i;

  // Grant only to the winner, response only to last cycle's winner
  always_comb begin
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      gnt_o[i]    = granted && (win == idx_w'(i));
      rvalid_o[i] = bank_rvalid_i && (rsp_win_q == idx_w'(i));
      // Data fans out, rvalid picks the owner
      rdata_o[i]  = bank_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q    <= '0;
      rsp_win_q <= '0;
    end else if (granted) begin
      // Last winner drops to lowest priority
      prio_q    <= idx_w'((win + 1) % N_PORTS);
      // Bank answers next cycle, remember who asked
      rsp_win_q <= win;
    end
  end

endmodule

// File: source/axi_lite_to_mem.sv
`timescale 1ns/100ps

`include "lite_mem_cfg.svh"

module axi_lite_to_mem import lite_mem_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  // AW channel
  input  lm_addr_t    awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  // W channel
  input  lm_data_t    wdata_i,
  input  lm_strb_t    wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  // B channel
  output lm_resp_t    bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  // AR channel
  input  lm_addr_t    araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  // R channel
  output lm_data_t    rdata_o,
  output lm_resp_t    rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  // Memory request side
  output logic        mem_req_o,
  output lm_mem_req_t mem_payload_o,
  input  logic        mem_gnt_i,
  input  logic        mem_rvalid_i,
  input  lm_data_t    mem_rdata_i
);

  // One transaction in flight at a time
  typedef enum logic [1:0] {
    s_idle,
    s_request,
    s_wait,
    s_respond
  } state_e;

  state_e      state_q;
  state_e      state_d;

  // Held request and response of the current transaction
  lm_mem_req_t payload_q;
  lm_resp_t    resp_q;
  lm_data_t    rdata_q;

  logic        idle;
  logic        write_pair;
  logic        write_go;
  logic        read_go;
  logic        resp_taken;
  lm_addr_t    sel_addr;
  logic        in_range;

  assign idle       = (state_q == s_idle);
  // AW and W are only taken together
  assign write_pair = awvalid_i && wvalid_i;

  // Write pair wins over a read in the same cycle
  assign awready_o = idle && write_pair;
  assign wready_o  = idle && write_pair;
  assign arready_o = idle && !write_pair;

  assign write_go = awready_o;
  assign read_go  = arready_o && arvalid_i;

  // Single range decode for whichever address is taken
  assign sel_addr = write_pair ? awaddr_i : araddr_i;
  assign in_range = (sel_addr < lm_addr_t'(`LM_MEM_BYTES));

  // Response leaves when the master takes it on B or R
  assign resp_taken = payload_q.we ? bready_i : rready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      s_idle: begin
        // Out of range goes straight to the response
        if (write_go || read_go) begin
          state_d = in_range ? s_request : s_respond;
        end
      end
      s_request: begin
        // Request drops the cycle after the grant
        if (mem_gnt_i) begin
          state_d = s_wait;
        end
      end
      s_wait: begin
        if (mem_rvalid_i) begin
          state_d = s_respond;
        end
      end
      s_respond: begin
        if (resp_taken) begin
          state_d = s_idle;
        end
      end
      default: state_d = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= s_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and response data, loaded at the address handshake
  always_ff @(posedge clk_i) begin
    if (write_go || read_go) begin
      payload_q.we    <= write_go;
      payload_q.index <= sel_addr[`LM_BYTE_OFF_W +: `LM_INDEX_W];
      payload_q.wdata <= write_go ? wdata_i : '0;
      payload_q.strb  <= write_go ? wstrb_i : '0;
      resp_q          <= in_range ? OKAY : SLVERR;
      // Decode errors read back as zero
      rdata_q         <= '0;
    end else if (state_q == s_wait && mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  // Memory side
  assign mem_req_o     = (state_q == s_request);
  assign mem_payload_o = payload_q;

  // B and R share the held response code
  assign bvalid_o = (state_q == s_respond) && payload_q.we;
  assign bresp_o  = resp_q;
  assign rvalid_o = (state_q == s_respond) && !payload_q.we;
  assign rresp_o  = resp_q;
  assign rdata_o  = rdata_q;

endmodule

// File: source/lite_mem_pkg.sv
`include "lite_mem_cfg.svh"

package lite_mem_pkg;

  // Byte address as seen on AW and AR
  typedef logic [`LM_ADDR_W-1:0] lm_addr_t;

  // One data word
  typedef logic [`LM_DATA_W-1:0] lm_data_t;

  // One strobe bit per byte lane
  typedef logic [`LM_STRB_W-1:0] lm_strb_t;

  // Word index into the bank
  typedef logic [`LM_INDEX_W-1:0] lm_index_t;

  // AXI response codes
  // Only OKAY and SLVERR are ever driven
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } lm_resp_t;

  // Single-word memory request, TCDM style
  // 1 + 8 + 32 + 4 = 45 bits
  typedef struct packed {
    // High for a write, low for a read
    logic      we;
    // Target word
    lm_index_t index;
    // Write data, zero on reads
    lm_data_t  wdata;
    // Byte enables, zero on reads
    lm_strb_t  strb;
  } lm_mem_req_t;

endpackage

// File: source/lite_mem_cfg.svh
`ifndef LITE_MEM_CFG_SVH
`define LITE_MEM_CFG_SVH

// Byte address width of both AXI4-Lite ports
`define LM_ADDR_W 32

// Data bus width, same on AXI and memory side
`define LM_DATA_W 32

// Memory depth in words
`define LM_MEM_WORDS 256

// Number of AXI4-Lite slave ports sharing the bank
`define LM_NUM_PORTS 2

// Byte lanes per word
`define LM_STRB_W (`LM_DATA_W / 8)

// Word index width, 8 bits for 256 words
`define LM_INDEX_W ($clog2(`LM_MEM_WORDS))

// Low address bits that select a byte within a word
`define LM_BYTE_OFF_W ($clog2(`LM_STRB_W))

// Size of the decoded range in bytes
`define LM_MEM_BYTES (`LM_MEM_WORDS * `LM_STRB_W)

`endif
